// ==== common/dac_pkg.sv ====
// shared widths, timing constants, config key, states and pin structs for the dac design
`default_nettype none

package dac_pkg;

  // dac element banks
  localparam int DSD_TAPS = 8;

  // one bank of element drive bits
  typedef logic [DSD_TAPS-1:0] dsd_bank_t;

  // full element drive for both channels
  typedef struct packed {
    dsd_bank_t lp;
    dsd_bank_t ln;
    dsd_bank_t rp;
    dsd_bank_t rn;
  } dsd_out_t;

  // raw dsd input pins
  typedef struct packed {
    logic bck;
    logic left;
    logic right;
  } dsd_in_t;

  // raw clock chip pins
  typedef struct packed {
    logic bck;
    logic lrck;
  } clk_chip_t;

  // clock chip configuration key, sent msb first
  localparam int CFG_KEY_BITS = 64;
  localparam logic [CFG_KEY_BITS-1:0] CFG_KEY = 64'h0aa5_aab5_a55a_aa50;

  // chip bck rising edges per key bit
  localparam int CFG_HOLD_TICKS = 4;
  // whole key is sent this many times
  localparam int CFG_REPEATS = 3;

  // sequencer counter widths
  localparam int HOLD_W = $clog2(CFG_HOLD_TICKS);
  localparam int KEY_IDX_W = $clog2(CFG_KEY_BITS);
  localparam int REP_W = $clog2(CFG_REPEATS);

  // lrck period measurement
  localparam int PERIOD_W = 12;
  localparam logic [PERIOD_W-1:0] PERIOD_MAX = '1;
  // pass when the period is below this many mclk cycles
  localparam int SELFTEST_LIMIT = 200;

  // element scrambler
  localparam int DEM_PATTERNS = 32;
  localparam int DEM_IDX_W = $clog2(DEM_PATTERNS);

  // configurator states
  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_SEND,
    CFG_MEASURE,
    CFG_DONE
  } cfg_state_e;

endpackage

`default_nettype wire

// ==== clock138/clock138_sequencer.sv ====
// clock chip configurator FSM, shifts the key out on chip bck ticks and then runs the self-test
`timescale 1ns/1ns
`default_nettype none

module clock138_sequencer (
  input  logic                         mclk,
  input  logic                         cfg_rst_n,
  input  logic                         chip_bck_tick_i,
  input  logic                         lrck_fall_i,
  input  logic                         measure_ack_i,
  input  logic [dac_pkg::PERIOD_W-1:0] period_count_i,
  output logic                         measure_req_o,
  output logic                         chip_data_o,
  output logic                         self_test_o,
  output logic                         cfg_done_o
);
  import dac_pkg::*;

  cfg_state_e state;

  // position in the key stream
  logic [HOLD_W-1:0]    hold_cnt;
  logic [KEY_IDX_W-1:0] bit_idx;
  logic [REP_W-1:0]     rep_cnt;
  logic [KEY_IDX_W-1:0] key_sel;
  logic                 hold_last;
  logic                 bit_last;
  logic                 rep_last;

  logic chip_data;
  logic measure_req;
  logic pass;
  logic cfg_done;

  // msb first
  assign key_sel = KEY_IDX_W'(CFG_KEY_BITS - 1) - bit_idx;

  assign hold_last = (hold_cnt == HOLD_W'(CFG_HOLD_TICKS - 1));
  assign bit_last  = (bit_idx == KEY_IDX_W'(CFG_KEY_BITS - 1));
  assign rep_last  = (rep_cnt == REP_W'(CFG_REPEATS - 1));

  always_ff @(posedge mclk or negedge cfg_rst_n) begin
    if (!cfg_rst_n) begin
      state       <= CFG_IDLE;
      hold_cnt    <= '0;
      bit_idx     <= '0;
      rep_cnt     <= '0;
      chip_data   <= 1'b0;
      measure_req <= 1'b0;
      pass        <= 1'b0;
      cfg_done    <= 1'b0;
    end else begin
      case (state)
        CFG_IDLE: begin
          // chip is ready once lrck runs
          if (lrck_fall_i) begin
            state <= CFG_SEND;
          end
        end
        CFG_SEND: begin
          if (chip_bck_tick_i) begin
            chip_data <= CFG_KEY[key_sel];
            if (hold_last) begin
              hold_cnt <= '0;
              if (bit_last) begin
                bit_idx <= '0;
                if (rep_last) begin
                  // last tick of the last key, start the self-test
                  state       <= CFG_MEASURE;
                  measure_req <= 1'b1;
                end else begin
                  rep_cnt <= rep_cnt + 1'b1;
                end
              end else begin
                bit_idx <= bit_idx + 1'b1;
              end
            end else begin
              hold_cnt <= hold_cnt + 1'b1;
            end
          end
        end
        CFG_MEASURE: begin
          // data line rests low after the key
          if (chip_bck_tick_i) begin
            chip_data <= 1'b0;
          end
          // sample count and release the request
          if (measure_req && measure_ack_i) begin
            pass        <= (period_count_i < PERIOD_W'(SELFTEST_LIMIT));
            measure_req <= 1'b0;
            cfg_done    <= 1'b1;
            state       <= CFG_DONE;
          end
        end
        CFG_DONE: begin
          // results held until reset
          state <= CFG_DONE;
        end
        default: begin
          state <= CFG_IDLE;
        end
      endcase
    end
  end

  assign measure_req_o = measure_req;
  assign chip_data_o   = chip_data;
  assign self_test_o   = pass;
  assign cfg_done_o    = cfg_done;

endmodule

`default_nettype wire

// ==== clock138/lrck_period_timer.sv ====
// measures one lrck period in mclk cycles on a req/ack request from the configurator
`timescale 1ns/1ns
`default_nettype none

module lrck_period_timer (
  input  logic                         mclk,
  input  logic                         cfg_rst_n,
  input  logic                         lrck_fall_i,
  input  logic                         measure_req_i,
  output logic                         measure_ack_o,
  output logic [dac_pkg::PERIOD_W-1:0] period_count_o
);
  import dac_pkg::*;

  // timer control
  typedef enum logic [1:0] {
    TMR_IDLE,
    TMR_ARMED,
    TMR_COUNT,
    TMR_ACK
  } tmr_state_e;

  tmr_state_e          state;
  logic [PERIOD_W-1:0] count;

  always_ff @(posedge mclk or negedge cfg_rst_n) begin
    if (!cfg_rst_n) begin
      state <= TMR_IDLE;
      count <= '0;
    end else begin
      case (state)
        TMR_IDLE: begin
          // ack is low here so a new request may start
          if (measure_req_i) begin
            state <= TMR_ARMED;
          end
        end
        TMR_ARMED: begin
          // first fall opens the window
          if (lrck_fall_i) begin
            count <= PERIOD_W'(1);
            state <= TMR_COUNT;
          end
        end
        TMR_COUNT: begin
          // count frozen from here until the next request
          if (lrck_fall_i) begin
            state <= TMR_ACK;
          end else if (count != PERIOD_MAX) begin
            count <= count + 1'b1;
          end
        end
        TMR_ACK: begin
          if (!measure_req_i) begin
            state <= TMR_IDLE;
          end
        end
        default: begin
          state <= TMR_IDLE;
        end
      endcase
    end
  end

  assign measure_ack_o  = (state == TMR_ACK);
  assign period_count_o = count;

endmodule

`default_nettype wire

// ==== dsd/dsd_history.sv ====
// dsd pin synchronizer and eight-tap bit histories, drives the positive and negative banks
`timescale 1ns/1ns
`default_nettype none

module dsd_history (
  input  logic              mclk,
  input  logic              reset_n,
  input  dac_pkg::dsd_in_t  dsd_i,
  output dac_pkg::dsd_out_t hist_o,
  output logic              step_o
);
  import dac_pkg::*;

  // two-stage pin synchronizer
  dsd_in_t pin_q1;
  dsd_in_t pin_q2;
  logic    bck_prev;
  logic    bck_rise;

  dsd_bank_t hist_l;
  dsd_bank_t hist_r;
  logic      step_q;
  dsd_out_t  bank_q;

  // negative bank is mirrored and inverted
  function automatic dsd_bank_t inv_rev(input dsd_bank_t b);
    dsd_bank_t r;
    for (int i = 0; i < DSD_TAPS; i++) begin
      r[i] = ~b[DSD_TAPS-1-i];
    end
    return r;
  endfunction

  assign bck_rise = pin_q2.bck & ~bck_prev;

  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      pin_q1   <= '0;
      pin_q2   <= '0;
      bck_prev <= 1'b0;
      hist_l   <= '0;
      hist_r   <= '0;
      step_q   <= 1'b0;
      bank_q   <= '{lp: '0, ln: '1, rp: '0, rn: '1};
    end else begin
      pin_q1   <= dsd_i;
      pin_q2   <= pin_q1;
      bck_prev <= pin_q2.bck;
      step_q   <= bck_rise;
      // newest bit enters at bit 0
      if (bck_rise) begin
        hist_l <= {hist_l[DSD_TAPS-2:0], pin_q2.left};
        hist_r <= {hist_r[DSD_TAPS-2:0], pin_q2.right};
      end
      // banks follow one cycle after the shift
      if (step_q) begin
        bank_q.lp <= hist_l;
        bank_q.ln <= inv_rev(hist_l);
        bank_q.rp <= hist_r;
        bank_q.rn <= inv_rev(hist_r);
      end
    end
  end

  assign hist_o = bank_q;
  assign step_o = step_q;

endmodule

`default_nettype wire

// ==== dsd/dem_scrambler.sv ====
// element shuffler for the positive banks, pair-wise permutation stepped once per dsd bit
`timescale 1ns/1ns
`default_nettype none

module dem_scrambler (
  input  logic              mclk,
  input  logic              reset_n,
  input  logic              step_i,
  input  logic              scramble_en_i,
  input  dac_pkg::dsd_out_t hist_i,
  output dac_pkg::dsd_out_t dac_o
);
  import dac_pkg::*;

  logic [DEM_IDX_W-1:0] pat_idx;
  // four two-bit pair selects, group 0 in the low bits
  logic [7:0]           pat;

  // pattern table as {p3, p2, p1, p0}
  function automatic logic [7:0] pat_of(input logic [DEM_IDX_W-1:0] idx);
    case (idx)
      5'd0:  return {2'd3, 2'd2, 2'd1, 2'd0};
      5'd1:  return {2'd2, 2'd3, 2'd1, 2'd0};
      5'd2:  return {2'd3, 2'd1, 2'd2, 2'd0};
      5'd3:  return {2'd1, 2'd3, 2'd2, 2'd0};
      5'd4:  return {2'd2, 2'd1, 2'd3, 2'd0};
      5'd5:  return {2'd1, 2'd2, 2'd3, 2'd0};
      5'd6:  return {2'd3, 2'd2, 2'd0, 2'd1};
      5'd7:  return {2'd2, 2'd3, 2'd0, 2'd1};
      5'd8:  return {2'd0, 2'd3, 2'd2, 2'd1};
      5'd9:  return {2'd3, 2'd0, 2'd2, 2'd1};
      5'd10: return {2'd2, 2'd0, 2'd3, 2'd1};
      5'd11: return {2'd0, 2'd2, 2'd3, 2'd1};
      5'd12: return {2'd1, 2'd0, 2'd3, 2'd2};
      5'd13: return {2'd0, 2'd1, 2'd3, 2'd2};
      5'd14: return {2'd0, 2'd3, 2'd1, 2'd2};
      5'd15: return {2'd3, 2'd0, 2'd1, 2'd2};
      5'd16: return {2'd3, 2'd1, 2'd0, 2'd2};
      5'd17: return {2'd1, 2'd3, 2'd0, 2'd2};
      5'd18: return {2'd1, 2'd2, 2'd0, 2'd3};
      5'd19: return {2'd2, 2'd1, 2'd0, 2'd3};
      5'd20: return {2'd2, 2'd0, 2'd1, 2'd3};
      5'd21: return {2'd0, 2'd2, 2'd1, 2'd3};
      5'd22: return {2'd1, 2'd0, 2'd2, 2'd3};
      5'd23: return {2'd0, 2'd1, 2'd2, 2'd3};
      // extra patterns reuse earlier orders
      5'd24: return {2'd0, 2'd1, 2'd2, 2'd3};
      5'd25: return {2'd0, 2'd3, 2'd1, 2'd2};
      5'd26: return {2'd1, 2'd3, 2'd2, 2'd0};
      5'd27: return {2'd3, 2'd2, 2'd0, 2'd1};
      5'd28: return {2'd0, 2'd2, 2'd3, 2'd1};
      5'd29: return {2'd3, 2'd2, 2'd1, 2'd0};
      5'd30: return {2'd2, 2'd1, 2'd0, 2'd3};
      default: return {2'd0, 2'd1, 2'd3, 2'd2};
    endcase
  endfunction

  // output pair g takes source pair sel, so the ones count is kept
  function automatic dsd_bank_t permute(input dsd_bank_t x, input logic [7:0] sel);
    dsd_bank_t y;
    logic [1:0] p;
    for (int g = 0; g < DSD_TAPS / 2; g++) begin
      p = sel[2*g +: 2];
      y[2*g]   = x[DSD_TAPS - 1 - 2*p];
      y[2*g+1] = x[DSD_TAPS - 2 - 2*p];
    end
    return y;
  endfunction

  // pattern index steps with every new dsd bit
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      pat_idx <= '0;
    end else if (step_i) begin
      pat_idx <= pat_idx + 1'b1;
    end
  end

  assign pat = pat_of(pat_idx);

  // negative banks never scrambled
  always_comb begin
    dac_o = hist_i;
    if (scramble_en_i) begin
      dac_o.lp = permute(hist_i.lp, pat);
      dac_o.rp = permute(hist_i.rp, pat);
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_top.sv ====
// top of the dac playback logic, clock chip sync and edge ticks plus the configurator and dsd path
`timescale 1ns/1ns
`default_nettype none

module dac_top (
  input  logic               mclk,
  input  logic               reset_n,
  input  dac_pkg::clk_chip_t chip_i,
  input  logic [1:0]         chip_en_i,
  input  dac_pkg::dsd_in_t   dsd_i,
  input  logic               scramble_en_i,
  output logic               chip_data_o,
  output logic               self_test_o,
  output logic               cfg_done_o,
  output dac_pkg::dsd_out_t  dac_o
);
  import dac_pkg::*;

  // clock chip pins, two sync stages plus a history stage
  clk_chip_t chip_q1;
  clk_chip_t chip_q2;
  clk_chip_t chip_q3;

  logic chip_bck_tick;
  logic lrck_fall;
  logic cfg_rst_n;

  // sequencer to timer handshake
  logic                measure_req;
  logic                measure_ack;
  logic [PERIOD_W-1:0] period_count;

  dsd_out_t hist;
  logic     hist_step;

  // configurator idles while both oscillators are off
  assign cfg_rst_n = reset_n & (|chip_en_i);

  // ticks land three cycles after the pin edge
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      chip_q1       <= '0;
      chip_q2       <= '0;
      chip_q3       <= '0;
      chip_bck_tick <= 1'b0;
      lrck_fall     <= 1'b0;
    end else begin
      chip_q1       <= chip_i;
      chip_q2       <= chip_q1;
      chip_q3       <= chip_q2;
      chip_bck_tick <= chip_q2.bck & ~chip_q3.bck;
      lrck_fall     <= ~chip_q2.lrck & chip_q3.lrck;
    end
  end

  clock138_sequencer u_seq (
    .mclk            (mclk),
    .cfg_rst_n       (cfg_rst_n),
    .chip_bck_tick_i (chip_bck_tick),
    .lrck_fall_i     (lrck_fall),
    .measure_ack_i   (measure_ack),
    .period_count_i  (period_count),
    .measure_req_o   (measure_req),
    .chip_data_o     (chip_data_o),
    .self_test_o     (self_test_o),
    .cfg_done_o      (cfg_done_o)
  );

  lrck_period_timer u_timer (
    .mclk           (mclk),
    .cfg_rst_n      (cfg_rst_n),
    .lrck_fall_i    (lrck_fall),
    .measure_req_i  (measure_req),
    .measure_ack_o  (measure_ack),
    .period_count_o (period_count)
  );

  // dsd path, history banks then scrambler
  dsd_history u_hist (
    .mclk    (mclk),
    .reset_n (reset_n),
    .dsd_i   (dsd_i),
    .hist_o  (hist),
    .step_o  (hist_step)
  );

  dem_scrambler u_dem (
    .mclk          (mclk),
    .reset_n       (reset_n),
    .step_i        (hist_step),
    .scramble_en_i (scramble_en_i),
    .hist_i        (hist),
    .dac_o         (dac_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_dac_top.sv ====
// dac_top testbench that checks reset, key, self-test and dsd banks for each data file record
`timescale 1ns/1ns
`default_nettype none

module tb_dac_top;
  import dac_pkg::*;

  // chip bck ticks for the whole key stream
  localparam int KEY_TICKS = CFG_KEY_BITS * CFG_HOLD_TICKS * CFG_REPEATS;
  // mclk cycles per bit clock half period
  localparam int HALF_BCK = 8;
  localparam int DONE_TIMEOUT = 20000;
  // observation window with both oscillators off
  localparam int OFF_CYCLES = 3000;

  logic       mclk;
  logic       reset_n;
  clk_chip_t  chip_i;
  logic [1:0] chip_en_i;
  dsd_in_t    dsd_i;
  logic       scramble_en_i;
  logic       chip_data_o;
  logic       self_test_o;
  logic       cfg_done_o;
  dsd_out_t   dac_o;

  // pin generator state
  bit gen_on;
  int half_cnt;
  int lrck_half;
  int lrck_cnt;
  bit lrck_fell;
  int key_rises;
  int keys_checked;

  // dsd bits of the current record
  dsd_bank_t seq_l;
  dsd_bank_t seq_r;
  int        dsd_sent;
  bit        dsd_checked;

  string test_name;
  int    err_mismatch;
  int    err_other;

  dac_top dut0 (
    .mclk          (mclk),
    .reset_n       (reset_n),
    .chip_i        (chip_i),
    .chip_en_i     (chip_en_i),
    .dsd_i         (dsd_i),
    .scramble_en_i (scramble_en_i),
    .chip_data_o   (chip_data_o),
    .self_test_o   (self_test_o),
    .cfg_done_o    (cfg_done_o),
    .dac_o         (dac_o)
  );

  always #2 mclk = ~mclk;

  task automatic report_mismatch(input string what, input string exp_s, input string act_s);
    err_mismatch++;
    $display("Mismatch %s %s: expected %s, actual %s", test_name, what, exp_s, act_s);
  endtask

  // complement with bit 0 moved to the top
  function automatic dsd_bank_t inv_mirror(input dsd_bank_t b);
    dsd_bank_t r;
    r = '0;
    for (int i = 0; i < DSD_TAPS; i++) begin
      r = {r[DSD_TAPS-2:0], ~b[i]};
    end
    return r;
  endfunction

  // data left by rise n is checked just before rise n+1
  task automatic check_key_bit();
    int   k;
    logic exp_bit;
    if (lrck_fell && chip_en_i != 2'b00) begin
      if (key_rises >= 1 && key_rises <= KEY_TICKS) begin
        k = key_rises - 1;
        exp_bit = CFG_KEY[CFG_KEY_BITS - 1 - (k / CFG_HOLD_TICKS) % CFG_KEY_BITS];
        if (chip_data_o !== exp_bit) begin
          report_mismatch($sformatf("key tick %0d", k), $sformatf("%b", exp_bit),
                          $sformatf("%b", chip_data_o));
        end
        keys_checked++;
      end
      key_rises++;
    end
  endtask

  task automatic check_banks();
    if (!scramble_en_i) begin
      if (dac_o.lp !== seq_l) begin
        report_mismatch("lp", $sformatf("%h", seq_l), $sformatf("%h", dac_o.lp));
      end
      if (dac_o.rp !== seq_r) begin
        report_mismatch("rp", $sformatf("%h", seq_r), $sformatf("%h", dac_o.rp));
      end
    end else begin
      // scrambled banks keep their ones count
      if ($countones(dac_o.lp) != $countones(seq_l)) begin
        report_mismatch("lp ones", $sformatf("%0d", $countones(seq_l)),
                        $sformatf("%0d", $countones(dac_o.lp)));
      end
      if ($countones(dac_o.rp) != $countones(seq_r)) begin
        report_mismatch("rp ones", $sformatf("%0d", $countones(seq_r)),
                        $sformatf("%0d", $countones(dac_o.rp)));
      end
    end
    if (dac_o.ln !== inv_mirror(seq_l)) begin
      report_mismatch("ln", $sformatf("%h", inv_mirror(seq_l)), $sformatf("%h", dac_o.ln));
    end
    if (dac_o.rn !== inv_mirror(seq_r)) begin
      report_mismatch("rn", $sformatf("%h", inv_mirror(seq_r)), $sformatf("%h", dac_o.rn));
    end
    dsd_checked = 1'b1;
  endtask

  // one mclk cycle with pins changing 1 ns after the edge
  task automatic tick();
    @(posedge mclk);
    #1;
    if (gen_on) begin
      half_cnt++;
      if (half_cnt == HALF_BCK) begin
        half_cnt = 0;
        if (chip_i.bck) begin
          // lrck and the next dsd bit change on the falling edge
          chip_i.bck = 1'b0;
          dsd_i.bck  = 1'b0;
          if (dsd_sent < DSD_TAPS) begin
            dsd_i.left  = seq_l[DSD_TAPS - 1 - dsd_sent];
            dsd_i.right = seq_r[DSD_TAPS - 1 - dsd_sent];
          end
          lrck_cnt++;
          if (lrck_cnt == lrck_half) begin
            lrck_cnt = 0;
            if (chip_i.lrck) begin
              lrck_fell = 1'b1;
            end
            chip_i.lrck = ~chip_i.lrck;
          end
        end else begin
          // sample just before the rise
          check_key_bit();
          if (dsd_sent == DSD_TAPS && !dsd_checked) begin
            check_banks();
          end
          chip_i.bck = 1'b1;
          // dsd bck stops after the eighth bit
          if (dsd_sent < DSD_TAPS) begin
            dsd_i.bck = 1'b1;
            dsd_sent++;
          end
        end
      end
    end
  endtask

  task automatic apply_reset(input logic [1:0] en, input logic scr, input int period);
    gen_on        = 1'b0;
    reset_n       = 1'b0;
    chip_en_i     = en;
    scramble_en_i = scr;
    chip_i.bck    = 1'b0;
    chip_i.lrck   = 1'b1;
    dsd_i.bck     = 1'b0;
    dsd_i.left    = seq_l[DSD_TAPS-1];
    dsd_i.right   = seq_r[DSD_TAPS-1];
    half_cnt      = 0;
    lrck_cnt      = 0;
    lrck_half     = period / 32;
    lrck_fell     = 1'b0;
    key_rises     = 0;
    keys_checked  = 0;
    dsd_sent      = 0;
    dsd_checked   = 1'b0;
    repeat (16) tick();
    reset_n = 1'b1;
    gen_on  = 1'b1;
  endtask

  task automatic run_record(input logic [1:0] en, input logic scr, input int period,
                            input logic exp_st);
    int n;
    bit off_bad;
    apply_reset(en, scr, period);
    if (chip_data_o !== 1'b0 || self_test_o !== 1'b0 || cfg_done_o !== 1'b0) begin
      report_mismatch("reset data/self_test/done", "0/0/0",
                      $sformatf("%b/%b/%b", chip_data_o, self_test_o, cfg_done_o));
    end
    if (dac_o !== dsd_out_t'{lp: '0, ln: '1, rp: '0, rn: '1}) begin
      report_mismatch("reset dac_o", "00ff00ff", $sformatf("%h", dac_o));
    end
    if (en == 2'b00) begin
      off_bad = 1'b0;
      for (n = 0; n < OFF_CYCLES; n++) begin
        tick();
        if (!off_bad && (chip_data_o !== 1'b0 || cfg_done_o !== 1'b0)) begin
          report_mismatch("oscillators off data/done", "0/0",
                          $sformatf("%b/%b", chip_data_o, cfg_done_o));
          off_bad = 1'b1;
        end
      end
    end else begin
      n = 0;
      while (cfg_done_o !== 1'b1 && n < DONE_TIMEOUT) begin
        tick();
        n++;
      end
      if (cfg_done_o !== 1'b1) begin
        err_other++;
        $display("Timeout in %s: cfg_done_o did not rise within %0d cycles", test_name,
                 DONE_TIMEOUT);
      end else begin
        if (self_test_o !== exp_st) begin
          report_mismatch("self_test_o", $sformatf("%b", exp_st), $sformatf("%b", self_test_o));
        end
        if (keys_checked != KEY_TICKS) begin
          err_other++;
          $display("Error in %s: only %0d of %0d key ticks were seen before cfg_done_o",
                   test_name, keys_checked, KEY_TICKS);
        end
      end
    end
    if (!dsd_checked) begin
      err_other++;
      $display("Error in %s: the dsd banks were never sampled", test_name);
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    int          records;
    string       line;
    string       name;
    logic [1:0]  en;
    dsd_bank_t   left;
    dsd_bank_t   right;
    logic        scr;
    logic        rnd;
    int          period;
    logic        exp_st;

    mclk          = 1'b0;
    reset_n       = 1'b0;
    chip_i        = '0;
    chip_en_i     = 2'b00;
    dsd_i         = '0;
    scramble_en_i = 1'b0;
    gen_on        = 1'b0;
    seq_l         = '0;
    seq_r         = '0;
    err_mismatch  = 0;
    err_other     = 0;
    records       = 0;
    test_name     = "none";
    void'($urandom(32'h5fcf_f791));

    fd = $fopen("test/dac_testdata.txt", "r");
    if (fd == 0) begin
      err_other++;
      $display("Error: cannot open test/dac_testdata.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        // skip comments and blank lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %h %h %h %h %h %d %h", name, en, left, right, scr, rnd,
                           period, exp_st);
          if (fields != 8) begin
            err_other++;
            $display("Error: malformed record line %s", line);
          end else begin
            test_name = name;
            // filler record draws its own dsd bits
            if (rnd) begin
              left  = dsd_bank_t'($urandom);
              right = dsd_bank_t'($urandom);
            end
            seq_l = left;
            seq_r = right;
            $display("Running %s", test_name);
            run_record(en, scr, period, exp_st);
            records++;
          end
        end
      end
      $fclose(fd);
    end
    if (records == 0) begin
      err_other++;
      $display("Error: no test records were read");
    end

    $display("Errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
    if (err_mismatch == 0 && err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/dac_testdata.txt ====
# columns: name chip_en left right scramble random lrck_period self_test
# hex fields except lrck_period (decimal mclk cycles, multiple of 32); dsd bits go out msb first
reset_fast_plain 3 b4 2d 0 0 128 1
slow_plain 3 96 c3 0 0 320 0
fast_scrambled 3 e1 5a 1 0 192 1
near_limit_fail 3 0f f0 1 0 224 0
single_osc 1 ff 00 0 0 160 1
random_filler 3 00 00 1 1 160 1
osc_off 0 a5 3c 0 0 128 0
slow_scrambled 2 7e 81 1 0 256 0

// ==== sources.f ====
common/dac_pkg.sv
clock138/clock138_sequencer.sv
clock138/lrck_period_timer.sv
dsd/dsd_history.sv
dsd/dem_scrambler.sv
source/dac_top.sv
test/tb_dac_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the dac testbench with Verilator, runs it and checks for the pass message

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

verilator --binary --timing --timescale 1ns/1ns --top-module tb_dac_top \
  -f sources.f --Mdir obj_dir -o tb_dac_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_dac_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
